/* common/spi_mem_pkg.sv */
// SPI to memory subsystem shared definitions
// Word type, client state encoding and reserved addresses

package spi_mem_pkg;

  // --------------------------------------------------------------------------
  // Frame and word sizes
  // --------------------------------------------------------------------------

  // SPI frame length, one full word per frame
  localparam int frame_bits = 32;

  // SPI frame, byte address or data word
  typedef logic [frame_bits-1:0] word_t;

  // --------------------------------------------------------------------------
  // Memory client FSM
  // --------------------------------------------------------------------------

  // Address frame first, then data frame
  // Then either a memory write or an update of go
  typedef enum logic [1:0] {
    // Idle, next frame is an address
    wait_addr,
    // Address stored, next frame is data
    wait_data,
    // Write request pending on the memory port
    wait_mem,
    // Data frame was for the go address
    set_go
  } client_state_e;

  // --------------------------------------------------------------------------
  // Reserved addresses
  // --------------------------------------------------------------------------

  // Data sent here drives go instead of memory
  localparam word_t go_addr = '0;

endpackage

/* flist.f */
common/spi_mem_pkg.sv
spi/spi_minion.sv
hdl/spi_mem_client.sv
hdl/word_mem.sv
hdl/spi_mem_top.sv
sim/spi_mem_props.sv
sim/spi_mem_tb.sv

/* hdl/spi_mem_client.sv */
// SPI memory client
// Pairs address and data frames into memory write requests
// The reserved go address updates the processor run enable instead

`timescale 1ns/10ps

module spi_mem_client (
  input  logic                 clk,
  input  logic                 rst,

  // From the SPI minion
  input  spi_mem_pkg::word_t   push_msg,
  input  logic                 push_en,

  // Write request to the word memory
  output logic                 req_val,
  input  logic                 req_rdy,
  output spi_mem_pkg::word_t   req_addr,
  output spi_mem_pkg::word_t   req_data,

  // Processor run enable
  output logic                 go
);

  // --------------------------------------------------------------------------
  // State register
  // --------------------------------------------------------------------------

  spi_mem_pkg::client_state_e state, next_state;

  always_ff @(posedge clk) begin
    if (rst)
      state <= spi_mem_pkg::wait_addr;
    else
      state <= next_state;
  end

  // --------------------------------------------------------------------------
  // Stored frames
  // --------------------------------------------------------------------------

  spi_mem_pkg::word_t addr_q;
  spi_mem_pkg::word_t data_q;

  // Captured on the matching push strobe
  always_ff @(posedge clk) begin
    if (state == spi_mem_pkg::wait_addr && push_en)
      addr_q <= push_msg;
  end

  always_ff @(posedge clk) begin
    if (state == spi_mem_pkg::wait_data && push_en)
      data_q <= push_msg;
  end

  // --------------------------------------------------------------------------
  // Next state
  // --------------------------------------------------------------------------

  always_comb begin
    next_state = state;
    case (state)
      spi_mem_pkg::wait_addr: begin
        if (push_en)
          next_state = spi_mem_pkg::wait_data;
      end
      spi_mem_pkg::wait_data: begin
        // Address already stored, decide on the data strobe
        if (push_en) begin
          if (addr_q == spi_mem_pkg::go_addr)
            next_state = spi_mem_pkg::set_go;
          else
            next_state = spi_mem_pkg::wait_mem;
        end
      end
      spi_mem_pkg::wait_mem: begin
        // Held until the memory accepts the write
        if (req_rdy)
          next_state = spi_mem_pkg::wait_addr;
      end
      spi_mem_pkg::set_go: begin
        next_state = spi_mem_pkg::wait_addr;
      end
      default: begin
        next_state = spi_mem_pkg::wait_addr;
      end
    endcase
  end

  // --------------------------------------------------------------------------
  // Run enable
  // --------------------------------------------------------------------------

  // Bit 0 of the data frame, one cycle after set_go
  always_ff @(posedge clk) begin
    if (rst)
      go <= 1'b0;
    else if (state == spi_mem_pkg::set_go)
      go <= data_q[0];
  end

  // --------------------------------------------------------------------------
  // Memory request
  // --------------------------------------------------------------------------

  // Stable while pending since both registers only load outside wait_mem
  assign req_val  = (state == spi_mem_pkg::wait_mem);
  assign req_addr = addr_q;
  assign req_data = data_q;

endmodule

/* hdl/spi_mem_top.sv */
// SPI to memory subsystem top level
// Chains SPI minion, memory client and word memory

`timescale 1ns/10ps

module spi_mem_top #(
  parameter int mem_depth_log2 = 8
) (
  input  logic                       clk,
  input  logic                       rst,

  // SPI host side
  input  logic                       cs,
  input  logic                       sclk,
  input  logic                       mosi,
  output logic                       miso,

  // Processor side
  input  logic                       rd_en,
  input  logic [mem_depth_log2-1:0]  rd_addr,
  output spi_mem_pkg::word_t         rd_data,
  output logic                       go
);

  // Minion to client
  spi_mem_pkg::word_t push_msg;
  logic               push_en;

  // Client to memory
  logic               req_val;
  logic               req_rdy;
  spi_mem_pkg::word_t req_addr;
  spi_mem_pkg::word_t req_data;

  spi_minion spi_minion_i (
    .clk      (clk),
    .rst      (rst),
    .cs       (cs),
    .sclk     (sclk),
    .mosi     (mosi),
    .miso     (miso),
    .push_msg (push_msg),
    .push_en  (push_en)
  );

  spi_mem_client spi_mem_client_i (
    .clk      (clk),
    .rst      (rst),
    .push_msg (push_msg),
    .push_en  (push_en),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_addr (req_addr),
    .req_data (req_data),
    .go       (go)
  );

  word_mem #(
    .mem_depth_log2 (mem_depth_log2)
  ) word_mem_i (
    .clk      (clk),
    .rst      (rst),
    .req_val  (req_val),
    .req_rdy  (req_rdy),
    .req_addr (req_addr),
    .req_data (req_data),
    .rd_en    (rd_en),
    .rd_addr  (rd_addr),
    .rd_data  (rd_data)
  );

endmodule

/* hdl/word_mem.sv */
// Single-port word memory
// Processor reads take priority over client write requests

`timescale 1ns/10ps

module word_mem #(
  parameter int mem_depth_log2 = 8
) (
  input  logic                       clk,
  input  logic                       rst,

  // Client write request
  input  logic                       req_val,
  output logic                       req_rdy,
  input  spi_mem_pkg::word_t         req_addr,
  input  spi_mem_pkg::word_t         req_data,

  // Processor read port
  input  logic                       rd_en,
  input  logic [mem_depth_log2-1:0]  rd_addr,
  output spi_mem_pkg::word_t         rd_data
);

  localparam int mem_depth = 2 ** mem_depth_log2;

  // --------------------------------------------------------------------------
  // Storage
  // --------------------------------------------------------------------------

  spi_mem_pkg::word_t mem [mem_depth];

  // --------------------------------------------------------------------------
  // Port arbitration
  // --------------------------------------------------------------------------

  // Read owns the port whenever requested
  assign req_rdy = ~rd_en;

  logic                       wr_en;
  logic [mem_depth_log2-1:0]  wr_idx;

  // Byte address to word index, upper bits alias
  assign wr_idx = req_addr[mem_depth_log2+1:2];

  // No writes land while in reset
  assign wr_en = req_val & req_rdy & ~rst;

  // --------------------------------------------------------------------------
  // Array access
  // --------------------------------------------------------------------------

  always_ff @(posedge clk) begin
    if (wr_en)
      mem[wr_idx] <= req_data;
  end

  // Valid the cycle after rd_en
  always_ff @(posedge clk) begin
    if (rd_en)
      rd_data <= mem[rd_addr];
  end

endmodule

/* run.sh */
#!/bin/sh
# Build and run the SPI memory testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -Wno-fatal --top-module spi_mem_tb \
  -f flist.f -o spi_mem_sim > build.log 2>&1 || { echo "build failed, see build.log"; exit 1; }

./obj_dir/spi_mem_sim > sim.log 2>&1

grep -q "test failed" sim.log && { echo "FAIL, see sim.log"; exit 1; } || \
  { grep -q "test passed" sim.log && echo "PASS"; }

/* sim/spi_mem_props.sv */
// Memory client checks
// Request handshake, go update and frame timing rules

`timescale 1ns/10ps

module spi_mem_props (
  input logic                       clk,
  input logic                       rst,
  input spi_mem_pkg::client_state_e state,
  input logic                       push_en,
  input logic                       req_val,
  input logic                       req_rdy,
  input spi_mem_pkg::word_t         req_addr,
  input spi_mem_pkg::word_t         req_data,
  input logic                       go
);

  // Stalled request held until transfer
  req_stable: assert property (@(posedge clk) disable iff (rst)
    req_val && !req_rdy |=> req_val && $stable(req_addr) && $stable(req_data))
    else $error("write request changed while stalled");

  // Back to idle after transfer
  req_done: assert property (@(posedge clk) disable iff (rst)
    req_val && req_rdy |=> !req_val)
    else $error("write request still valid after transfer");

  // go moves only out of set_go
  go_update: assert property (@(posedge clk) disable iff (rst)
    go != $past(go) |-> $past(state) == spi_mem_pkg::set_go)
    else $error("go changed outside set_go");

  // A frame here would be dropped
  no_lost_frame: assert property (@(posedge clk) disable iff (rst)
    state == spi_mem_pkg::wait_mem |-> !push_en)
    else $error("frame arrived while a write was stalled");

endmodule

bind spi_mem_client spi_mem_props spi_mem_props_i (
  .clk      (clk),
  .rst      (rst),
  .state    (state),
  .push_en  (push_en),
  .req_val  (req_val),
  .req_rdy  (req_rdy),
  .req_addr (req_addr),
  .req_data (req_data),
  .go       (go)
);

/* sim/spi_mem_tb.sv */
// Testbench for the SPI to memory subsystem
// Runs write, go and read tests from a data file over SPI and the read port

`timescale 1ns/10ps

module spi_mem_tb;

  localparam int mem_depth_log2 = 8;
  localparam int max_tests = 64;
  // Two frames of about 265 cycles each, plus waits and read bursts
  localparam int cycles_per_test = 800;

  logic                       clk;
  logic                       rst;
  logic                       cs;
  logic                       sclk;
  logic                       mosi;
  logic                       miso;
  logic                       rd_en;
  logic [mem_depth_log2-1:0]  rd_addr;
  spi_mem_pkg::word_t         rd_data;
  logic                       go;

  // --------------------------------------------------------------------------
  // Test table and reference state
  // --------------------------------------------------------------------------

  logic [8*16-1:0]    test_kind [max_tests];
  logic [8*16-1:0]    test_name [max_tests];
  spi_mem_pkg::word_t test_addr [max_tests];
  spi_mem_pkg::word_t test_data [max_tests];
  spi_mem_pkg::word_t test_exp  [max_tests];
  int                 n_tests;

  // Words already written, by word index
  spi_mem_pkg::word_t known_words [int];
  // Expected on miso during the next frame
  spi_mem_pkg::word_t last_mosi;
  int                 seed = 32'hd6ee_236e;
  int                 cycle_cnt = 0;
  int                 cycle_limit = 0;

  spi_mem_top #(
    .mem_depth_log2 (mem_depth_log2)
  ) spi_mem_top_i (
    .clk     (clk),
    .rst     (rst),
    .cs      (cs),
    .sclk    (sclk),
    .mosi    (mosi),
    .miso    (miso),
    .rd_en   (rd_en),
    .rd_addr (rd_addr),
    .rd_data (rd_data),
    .go      (go)
  );

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  // Watchdog on total run length
  always @(posedge clk) begin
    cycle_cnt = cycle_cnt + 1;
    if (cycle_limit != 0 && cycle_cnt > cycle_limit) begin
      $display("run did not finish within %0d cycles", cycle_limit);
      $display("test failed");
      $fatal(1, "timeout");
    end
  end

  // --------------------------------------------------------------------------
  // Helpers
  // --------------------------------------------------------------------------

  task automatic check(input string name, input spi_mem_pkg::word_t expected,
                       input spi_mem_pkg::word_t actual);
    if (actual !== expected) begin
      $display("ERROR %0s expected %h actual %h", name, expected, actual);
      $display("test failed");
      $fatal(1, "value mismatch");
    end
  endtask

  // Ends 1 ns after a rising edge, where inputs are driven
  task automatic wait_cycles(input int n);
    repeat (n) begin
      @(posedge clk);
      #1;
    end
  endtask

  function automatic int random_gap();
    return $random(seed) & 32'h3;
  endfunction

  // Byte address to word index, upper bits alias
  function automatic logic [mem_depth_log2-1:0] word_index(input spi_mem_pkg::word_t addr);
    return addr[mem_depth_log2+1:2];
  endfunction

  task automatic load_tests();
    int                 fd;
    logic [8*16-1:0]    kind;
    logic [8*16-1:0]    name;
    spi_mem_pkg::word_t addr;
    spi_mem_pkg::word_t data;
    spi_mem_pkg::word_t exp;
    fd = $fopen("sim/spi_mem_tests.txt", "r");
    if (fd == 0) begin
      $display("could not open sim/spi_mem_tests.txt");
      $display("test failed");
      $fatal(1, "missing tests file");
    end
    n_tests = 0;
    while (n_tests < max_tests &&
           $fscanf(fd, "%s %s %h %h %h\n", kind, name, addr, data, exp) == 5) begin
      test_kind[n_tests] = kind;
      test_name[n_tests] = name;
      test_addr[n_tests] = addr;
      test_data[n_tests] = data;
      test_exp[n_tests]  = exp;
      n_tests = n_tests + 1;
    end
    $fclose(fd);
  endtask

  // One mode 0 frame, MSB first, 4 clk cycles per sclk phase
  // miso is taken just before each sclk rise
  task automatic send_frame(input string name, input spi_mem_pkg::word_t tx);
    spi_mem_pkg::word_t rx;
    int                 i;
    cs   = 1'b0;
    sclk = 1'b0;
    for (i = spi_mem_pkg::frame_bits - 1; i >= 0; i--) begin
      mosi = tx[i];
      wait_cycles(4);
      rx[i] = miso;
      sclk  = 1'b1;
      wait_cycles(4);
      sclk = 1'b0;
    end
    wait_cycles(4);
    cs = 1'b1;
    // Loop-back returns the previous frame
    check($sformatf("%0s_miso", name), last_mosi, rx);
    last_mosi = tx;
  endtask

  task automatic read_word(input logic [mem_depth_log2-1:0] idx,
                           output spi_mem_pkg::word_t data);
    rd_en   = 1'b1;
    rd_addr = idx;
    wait_cycles(1);
    rd_en = 1'b0;
    data  = rd_data;
  endtask

  // Address and data frame, with reads stalling the pending write
  task automatic run_write(input string name, input spi_mem_pkg::word_t addr,
                           input spi_mem_pkg::word_t data, input spi_mem_pkg::word_t exp);
    logic [mem_depth_log2-1:0] idx;
    spi_mem_pkg::word_t        got;
    idx = word_index(addr);
    send_frame(name, addr);
    wait_cycles(4);
    send_frame(name, data);
    wait_cycles(random_gap());
    // rd_en covers the cycles where the request becomes valid
    rd_en   = 1'b1;
    rd_addr = idx;
    repeat (8) begin
      wait_cycles(1);
      if (known_words.exists(idx))
        check($sformatf("%0s_stall", name), known_words[idx], rd_data);
    end
    rd_en = 1'b0;
    wait_cycles(8);
    known_words[idx] = data;
    read_word(idx, got);
    check(name, exp, got);
  endtask

  task automatic run_go(input string name, input spi_mem_pkg::word_t data,
                        input spi_mem_pkg::word_t exp);
    send_frame(name, spi_mem_pkg::go_addr);
    wait_cycles(4);
    send_frame(name, data);
    wait_cycles(8);
    check(name, exp, {31'd0, go});
  endtask

  task automatic run_read(input string name, input spi_mem_pkg::word_t addr,
                          input spi_mem_pkg::word_t exp);
    spi_mem_pkg::word_t got;
    wait_cycles(random_gap());
    read_word(word_index(addr), got);
    check(name, exp, got);
  endtask

  // --------------------------------------------------------------------------
  // Main sequence
  // --------------------------------------------------------------------------

  initial begin
    rst       = 1'b1;
    cs        = 1'b1;
    sclk      = 1'b0;
    mosi      = 1'b0;
    rd_en     = 1'b0;
    rd_addr   = '0;
    last_mosi = '0;
    load_tests();
    if (n_tests == 0) begin
      $display("no tests found in sim/spi_mem_tests.txt");
      $display("test failed");
      $fatal(1, "empty tests file");
    end
    cycle_limit = n_tests * cycles_per_test + 1000;
    wait_cycles(8);
    rst = 1'b0;
    wait_cycles(1);
    check("reset_go", 32'd0, {31'd0, go});
    for (int t = 0; t < n_tests; t++) begin
      if (test_kind[t] == "write")
        run_write($sformatf("%0s", test_name[t]), test_addr[t], test_data[t], test_exp[t]);
      else if (test_kind[t] == "go")
        run_go($sformatf("%0s", test_name[t]), test_data[t], test_exp[t]);
      else if (test_kind[t] == "read")
        run_read($sformatf("%0s", test_name[t]), test_addr[t], test_exp[t]);
      else begin
        $display("unknown test kind %0s in the tests file", test_kind[t]);
        $display("test failed");
        $fatal(1, "bad tests file");
      end
    end
    $display("test passed");
    $finish;
  end

endmodule

/* sim/spi_mem_tests.txt */
write wr_a 00000010 cafef00d cafef00d
write wr_b 00000014 12345678 12345678
read rd_a 00000010 00000000 cafef00d
write wr_zero 00000400 a5a5a5a5 a5a5a5a5
go go_on 00000000 00000001 00000001
read rd_zero 00000000 00000000 a5a5a5a5
go go_off 00000000 00000002 00000000
read rd_zero_again 00000000 00000000 a5a5a5a5
write wr_over 00000010 0badbeef 0badbeef
write wr_alias 00000c14 87654321 87654321
read rd_alias 00000014 00000000 87654321
write wr_top 000003fc deadbeef deadbeef
write wr_top_alias 000007fc 13579bdf 13579bdf
go go_odd 00000000 ffffffff 00000001
read rd_over 00000010 00000000 0badbeef
read rd_top 000003fc 00000000 13579bdf
go go_clear 00000000 fffffffe 00000000
read rd_zero_last 00000000 00000000 a5a5a5a5

/* spi/spi_minion.sv */
// SPI minion, mode 0, MSB first
// Turns 32-bit serial frames into push strobes on the clk domain
// miso loops back the word received in the previous frame

`timescale 1ns/10ps

module spi_minion (
  input  logic                 clk,
  input  logic                 rst,
  input  logic                 cs,
  input  logic                 sclk,
  input  logic                 mosi,
  output logic                 miso,
  output spi_mem_pkg::word_t   push_msg,
  output logic                 push_en
);

  // Counter wide enough to hold a full frame count
  localparam int cnt_bits = $clog2(spi_mem_pkg::frame_bits + 1);

  // --------------------------------------------------------------------------
  // Synchronizers and edge detect
  // --------------------------------------------------------------------------

  logic cs_meta, cs_sync, cs_prev;
  logic sclk_meta, sclk_sync, sclk_prev;
  logic mosi_meta, mosi_sync;

  // cs idles high, sclk idles low in mode 0
  always_ff @(posedge clk) begin
    if (rst) begin
      cs_meta   <= 1'b1;
      cs_sync   <= 1'b1;
      cs_prev   <= 1'b1;
      sclk_meta <= 1'b0;
      sclk_sync <= 1'b0;
      sclk_prev <= 1'b0;
    end else begin
      cs_meta   <= cs;
      cs_sync   <= cs_meta;
      cs_prev   <= cs_sync;
      sclk_meta <= sclk;
      sclk_sync <= sclk_meta;
      sclk_prev <= sclk_sync;
    end
  end

  // Same delay as sclk so data lines up with the rising edge
  always_ff @(posedge clk) begin
    mosi_meta <= mosi;
    mosi_sync <= mosi_meta;
  end

  logic sclk_rise, sclk_fall, cs_rise, cs_fall;

  assign sclk_rise = sclk_sync & ~sclk_prev & ~cs_sync;
  assign sclk_fall = ~sclk_sync & sclk_prev & ~cs_sync;
  assign cs_rise   = cs_sync & ~cs_prev;
  assign cs_fall   = ~cs_sync & cs_prev;

  // --------------------------------------------------------------------------
  // Receive path
  // --------------------------------------------------------------------------

  spi_mem_pkg::word_t   rx_reg;
  logic [cnt_bits-1:0]  bit_cnt;

  // Sample on sclk rise, MSB arrives first
  always_ff @(posedge clk) begin
    if (sclk_rise)
      rx_reg <= {rx_reg[spi_mem_pkg::frame_bits-2:0], mosi_sync};
  end

  // Bit count restarts with each frame, saturates on overlong frames
  always_ff @(posedge clk) begin
    if (rst)
      bit_cnt <= '0;
    else if (cs_fall)
      bit_cnt <= '0;
    else if (sclk_rise && bit_cnt != '1)
      bit_cnt <= bit_cnt + 1'b1;
  end

  // Push only frames of exactly frame_bits pulses
  always_ff @(posedge clk) begin
    if (rst)
      push_en <= 1'b0;
    else
      push_en <= cs_rise && (bit_cnt == cnt_bits'(spi_mem_pkg::frame_bits));
  end

  // Held until the next frame starts shifting
  assign push_msg = rx_reg;

  // --------------------------------------------------------------------------
  // Transmit loop-back
  // --------------------------------------------------------------------------

  spi_mem_pkg::word_t last_word;
  spi_mem_pkg::word_t tx_reg;

  // Zero until the first full frame
  always_ff @(posedge clk) begin
    if (rst)
      last_word <= '0;
    else if (push_en)
      last_word <= rx_reg;
  end

  // Load at frame start, shift on sclk fall
  always_ff @(posedge clk) begin
    if (rst)
      tx_reg <= '0;
    else if (cs_fall)
      tx_reg <= last_word;
    else if (sclk_fall)
      tx_reg <= {tx_reg[spi_mem_pkg::frame_bits-2:0], 1'b0};
  end

  assign miso = tx_reg[spi_mem_pkg::frame_bits-1];

endmodule
